// File: logic/bev_pkg.sv
`default_nettype none

package bev_pkg;

	// ========================================
	// widths
	// ========================================
	localparam int ING_W = 12;
	localparam int BUS_W = 12;

	typedef logic [ING_W-1:0] ing_t;
	typedef logic [3:0]       month_t;
	typedef logic [4:0]       day_t;
	typedef logic [7:0]       box_t;
	typedef logic [63:0]      barrel_t;
	typedef logic [BUS_W-1:0] bus_t;

	// ========================================
	// encodings
	// ========================================
	typedef enum logic {Make_drink, Supply} action_t;

	typedef enum logic [2:0] {
		Black_Tea, Milk_Tea, Extra_Milk_Tea, Green_Tea,
		Green_Milk_Tea, Pineapple_Juice, Super_Pineapple_Tea, Super_Pineapple_Milk_Tea
	} bev_type_t;

	typedef enum logic [1:0] {L, M, S} bev_size_t;

	typedef enum logic [1:0] {No_Err, No_Exp, No_Ing, Ing_OF} err_t;

	typedef enum logic [3:0] {
		IDLE, GET_INFO, READ_REQ, READ_WAIT, CHECK,
		UPDATE, WRITE_REQ, WRITE_WAIT, DONE
	} state_t;

	// ========================================
	// barrel record layout
	// ========================================
	localparam int BLACK_LSB = 52;
	localparam int GREEN_LSB = 40;
	localparam int MONTH_LSB = 32;
	localparam int MILK_LSB  = 20;
	localparam int PINE_LSB  = 8;
	localparam int DAY_LSB   = 0;

	// ingredient index order 0 black, 1 green, 2 milk, 3 pineapple
	localparam int ING_LSB [0:3] = '{BLACK_LSB, GREEN_LSB, MILK_LSB, PINE_LSB};

	localparam ing_t ING_MAX = 12'd4095;

	// total volume per cup size
	localparam ing_t VOL_L = 12'd960;
	localparam ing_t VOL_M = 12'd720;
	localparam ing_t VOL_S = 12'd480;

endpackage

`default_nettype wire

// File: logic/bev_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module bev_ctrl (
	input  logic              clk,
	input  logic              inf_n,
	input  logic              act_valid,
	input  logic              box_valid,
	input  logic              c_out_valid,
	input  logic              sup_done,
	input  logic              expired,
	input  logic              short,
	input  logic              overflow,
	input  bev_pkg::action_t  action,
	output logic              barrel_load,
	output logic              upd_en,
	output logic              clear,
	output logic              c_in_valid,
	output logic              c_r_wb,
	output logic              out_valid,
	output logic              complete,
	output logic [1:0]        step,
	output bev_pkg::err_t     err
);

	bev_pkg::state_t state, next_state;
	logic [1:0] step_q;
	// read reply already seen, supply may still wait on strobes
	logic got_rd;

	// ========================================
	// order FSM
	// ========================================
	always_ff @(posedge clk or negedge inf_n) begin
		if (!inf_n) begin
			state <= bev_pkg::IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			bev_pkg::IDLE: begin
				if (act_valid) next_state = bev_pkg::GET_INFO;
			end
			bev_pkg::GET_INFO: begin
				if (box_valid) next_state = bev_pkg::READ_REQ;
			end
			bev_pkg::READ_REQ: next_state = bev_pkg::READ_WAIT;
			bev_pkg::READ_WAIT: begin
				// make goes to the checks, supply needs record and all four amounts
				if (action == bev_pkg::Make_drink) begin
					if (c_out_valid) next_state = bev_pkg::CHECK;
				end else if ((got_rd || c_out_valid) && sup_done) begin
					next_state = bev_pkg::UPDATE;
				end
			end
			bev_pkg::CHECK: begin
				if (expired || short) next_state = bev_pkg::DONE;
				else next_state = bev_pkg::UPDATE;
			end
			bev_pkg::UPDATE: begin
				if (step_q == 2'd3) next_state = bev_pkg::WRITE_REQ;
			end
			bev_pkg::WRITE_REQ: next_state = bev_pkg::WRITE_WAIT;
			bev_pkg::WRITE_WAIT: begin
				if (c_out_valid) next_state = bev_pkg::DONE;
			end
			bev_pkg::DONE: begin
				// a new order may start right after the result
				if (act_valid) next_state = bev_pkg::GET_INFO;
				else next_state = bev_pkg::IDLE;
			end
			default: next_state = bev_pkg::IDLE;
		endcase
	end

	// ========================================
	// update sequencing
	// ========================================
	assign barrel_load = (state == bev_pkg::READ_WAIT) && c_out_valid;
	assign upd_en      = (state == bev_pkg::UPDATE);
	assign clear       = (state == bev_pkg::IDLE) || (state == bev_pkg::DONE);
	assign step        = step_q;

	always_ff @(posedge clk or negedge inf_n) begin
		if (!inf_n) begin
			step_q <= 2'd0;
			got_rd <= 1'b0;
		end else begin
			if (state == bev_pkg::UPDATE) step_q <= step_q + 2'd1;
			else step_q <= 2'd0;
			if (clear) got_rd <= 1'b0;
			else if (barrel_load) got_rd <= 1'b1;
		end
	end

	// ========================================
	// registered bridge and result outputs
	// ========================================
	always_ff @(posedge clk or negedge inf_n) begin
		if (!inf_n) begin
			c_in_valid <= 1'b0;
			c_r_wb     <= 1'b1;
			out_valid  <= 1'b0;
			err        <= bev_pkg::No_Err;
			complete   <= 1'b0;
		end else begin
			// request pulse lines up with the REQ states
			c_in_valid <= (next_state == bev_pkg::READ_REQ) || (next_state == bev_pkg::WRITE_REQ);
			c_r_wb     <= (next_state != bev_pkg::WRITE_REQ);
			out_valid  <= (next_state == bev_pkg::DONE);
			if (next_state == bev_pkg::DONE && state == bev_pkg::CHECK) begin
				// expiry wins over shortage
				err      <= expired ? bev_pkg::No_Exp : bev_pkg::No_Ing;
				complete <= 1'b0;
			end else if (next_state == bev_pkg::DONE) begin
				err      <= overflow ? bev_pkg::Ing_OF : bev_pkg::No_Err;
				complete <= !overflow;
			end else begin
				err      <= bev_pkg::No_Err;
				complete <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/order_capture.sv
`timescale 1ns/1ns
`default_nettype none

module order_capture (
	input  logic                clk,
	input  logic                inf_n,
	input  logic                clear,
	input  logic                type_valid,
	input  logic                size_valid,
	input  logic                date_valid,
	input  logic                box_valid,
	input  logic                sup_valid,
	input  logic                act_valid,
	input  bev_pkg::bus_t       d,
	output bev_pkg::action_t    action,
	output bev_pkg::bev_type_t  bev_type,
	output bev_pkg::bev_size_t  bev_size,
	output bev_pkg::month_t     today_month,
	output bev_pkg::day_t       today_day,
	output bev_pkg::box_t       c_addr,
	output bev_pkg::ing_t       supply [0:3],
	output logic                sup_done
);

	// slot for the next supply amount
	logic [1:0] sup_cnt;

	// ========================================
	// order fields
	// ========================================
	always_ff @(posedge clk or negedge inf_n) begin
		if (!inf_n) begin
			action      <= bev_pkg::Make_drink;
			bev_type    <= bev_pkg::Black_Tea;
			bev_size    <= bev_pkg::L;
			today_month <= '0;
			today_day   <= '0;
			c_addr      <= '0;
		end else begin
			if (act_valid) action <= bev_pkg::action_t'(d[0]);
			if (type_valid) bev_type <= bev_pkg::bev_type_t'(d[2:0]);
			if (size_valid) bev_size <= bev_pkg::bev_size_t'(d[1:0]);
			// month on 8:5, day on 4:0
			if (date_valid) begin
				today_month <= d[8:5];
				today_day   <= d[4:0];
			end
			if (box_valid) c_addr <= d[7:0];
		end
	end

	// ========================================
	// supply amounts, index order
	// ========================================
	always_ff @(posedge clk) begin
		if (sup_valid) supply[sup_cnt] <= d;
	end

	always_ff @(posedge clk or negedge inf_n) begin
		if (!inf_n) begin
			sup_cnt  <= 2'd0;
			sup_done <= 1'b0;
		end else if (clear) begin
			sup_cnt  <= 2'd0;
			sup_done <= 1'b0;
		end else if (sup_valid) begin
			sup_cnt <= sup_cnt + 2'd1;
			// fourth amount latched
			if (sup_cnt == 2'd3) sup_done <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: logic/recipe_check.sv
`timescale 1ns/1ns
`default_nettype none

module recipe_check (
	input  bev_pkg::bev_type_t  bev_type,
	input  bev_pkg::bev_size_t  bev_size,
	input  bev_pkg::month_t     today_month,
	input  bev_pkg::day_t       today_day,
	input  bev_pkg::barrel_t    barrel,
	output bev_pkg::ing_t       need [0:3],
	output logic                expired,
	output logic                short
);

	bev_pkg::ing_t   vol, half, quarter;
	bev_pkg::month_t b_month;
	bev_pkg::day_t   b_day;

	// ========================================
	// recipe table
	// ========================================
	always_comb begin
		case (bev_size)
			bev_pkg::L: vol = bev_pkg::VOL_L;
			bev_pkg::M: vol = bev_pkg::VOL_M;
			default:    vol = bev_pkg::VOL_S;
		endcase
	end

	assign half    = vol >> 1;
	assign quarter = vol >> 2;

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			need[i] = '0;
		end
		// 0 black, 1 green, 2 milk, 3 pineapple
		case (bev_type)
			bev_pkg::Black_Tea: need[0] = vol;
			bev_pkg::Milk_Tea: begin
				need[0] = vol - quarter;
				need[2] = quarter;
			end
			bev_pkg::Extra_Milk_Tea: begin
				need[0] = half;
				need[2] = half;
			end
			bev_pkg::Green_Tea: need[1] = vol;
			bev_pkg::Green_Milk_Tea: begin
				need[1] = half;
				need[2] = half;
			end
			bev_pkg::Pineapple_Juice: need[3] = vol;
			bev_pkg::Super_Pineapple_Tea: begin
				need[0] = half;
				need[3] = half;
			end
			default: begin
				need[0] = half;
				need[2] = quarter;
				need[3] = quarter;
			end
		endcase
	end

	// ========================================
	// expiry and sufficiency
	// ========================================
	// date fields only use their low bits
	assign b_month = barrel[bev_pkg::MONTH_LSB +: $bits(bev_pkg::month_t)];
	assign b_day   = barrel[bev_pkg::DAY_LSB +: $bits(bev_pkg::day_t)];

	assign expired = (b_month < today_month) || ((b_month == today_month) && (b_day < today_day));

	always_comb begin
		short = 1'b0;
		for (int i = 0; i < 4; i++) begin
			if (barrel[bev_pkg::ING_LSB[i] +: bev_pkg::ING_W] < need[i]) short = 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: logic/barrel_update.sv
`timescale 1ns/1ns
`default_nettype none

module barrel_update (
	input  logic              clk,
	input  logic              inf_n,
	input  logic              clear,
	input  logic              barrel_load,
	input  logic              upd_en,
	input  logic [1:0]        step,
	input  bev_pkg::action_t  action,
	input  bev_pkg::barrel_t  c_data_r,
	input  bev_pkg::ing_t     need [0:3],
	input  bev_pkg::ing_t     supply [0:3],
	input  bev_pkg::month_t   today_month,
	input  bev_pkg::day_t     today_day,
	output bev_pkg::barrel_t  barrel,
	output bev_pkg::barrel_t  c_data_w,
	output logic              overflow
);

	bev_pkg::ing_t old_val, new_val;
	// one extra bit for the carry out
	logic [bev_pkg::ING_W:0] sum;
	logic sat;

	// ========================================
	// one ingredient per step
	// ========================================
	assign old_val = barrel[bev_pkg::ING_LSB[step] +: bev_pkg::ING_W];
	assign sum     = {1'b0, old_val} + {1'b0, supply[step]};
	assign sat     = sum[bev_pkg::ING_W];

	always_comb begin
		if (action == bev_pkg::Supply) begin
			// clip at full barrel
			new_val = sat ? bev_pkg::ING_MAX : sum[bev_pkg::ING_W-1:0];
		end else begin
			// sufficiency already checked, no borrow here
			new_val = old_val - need[step];
		end
	end

	// ========================================
	// record register
	// ========================================
	always_ff @(posedge clk) begin
		if (barrel_load) begin
			barrel <= c_data_r;
		end else if (upd_en) begin
			barrel[bev_pkg::ING_LSB[step] +: bev_pkg::ING_W] <= new_val;
			// supply restamps the barrel date
			if (action == bev_pkg::Supply && step == 2'd0) begin
				barrel[bev_pkg::MONTH_LSB +: 8] <= {4'd0, today_month};
				barrel[bev_pkg::DAY_LSB +: 8]   <= {3'd0, today_day};
			end
		end
	end

	assign c_data_w = barrel;

	// sticky over all four steps of a supply
	always_ff @(posedge clk or negedge inf_n) begin
		if (!inf_n) begin
			overflow <= 1'b0;
		end else if (clear) begin
			overflow <= 1'b0;
		end else if (upd_en && action == bev_pkg::Supply && sat) begin
			overflow <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: logic/bev_top.sv
`timescale 1ns/1ns
`default_nettype none

module bev_top (
	input  logic              clk,
	input  logic              inf_n,
	input  bev_pkg::bus_t     d,
	input  logic              act_valid,
	input  logic              type_valid,
	input  logic              size_valid,
	input  logic              date_valid,
	input  logic              box_valid,
	input  logic              sup_valid,
	input  logic              c_out_valid,
	input  bev_pkg::barrel_t  c_data_r,
	output logic              out_valid,
	output logic              complete,
	output logic              c_in_valid,
	output logic              c_r_wb,
	output bev_pkg::err_t     err,
	output bev_pkg::box_t     c_addr,
	output bev_pkg::barrel_t  c_data_w
);

	// latched order
	bev_pkg::action_t   action;
	bev_pkg::bev_type_t bev_type;
	bev_pkg::bev_size_t bev_size;
	bev_pkg::month_t    today_month;
	bev_pkg::day_t      today_day;
	bev_pkg::ing_t      supply [0:3];
	logic               sup_done;

	// control and check results
	logic               barrel_load, upd_en, clear;
	logic [1:0]         step;
	bev_pkg::ing_t      need [0:3];
	logic               expired, short, overflow;
	bev_pkg::barrel_t   barrel;

	bev_ctrl u_ctrl (
		.clk(clk), .inf_n(inf_n), .act_valid(act_valid), .box_valid(box_valid),
		.c_out_valid(c_out_valid), .sup_done(sup_done), .expired(expired), .short(short),
		.overflow(overflow), .action(action), .barrel_load(barrel_load), .upd_en(upd_en),
		.clear(clear), .c_in_valid(c_in_valid), .c_r_wb(c_r_wb), .out_valid(out_valid),
		.complete(complete), .step(step), .err(err)
	);

	order_capture u_capture (
		.clk(clk), .inf_n(inf_n), .clear(clear), .type_valid(type_valid),
		.size_valid(size_valid), .date_valid(date_valid), .box_valid(box_valid),
		.sup_valid(sup_valid), .act_valid(act_valid), .d(d), .action(action),
		.bev_type(bev_type), .bev_size(bev_size), .today_month(today_month),
		.today_day(today_day), .c_addr(c_addr), .supply(supply), .sup_done(sup_done)
	);

	recipe_check u_check (
		.bev_type(bev_type), .bev_size(bev_size), .today_month(today_month),
		.today_day(today_day), .barrel(barrel), .need(need), .expired(expired), .short(short)
	);

	barrel_update u_update (
		.clk(clk), .inf_n(inf_n), .clear(clear), .barrel_load(barrel_load), .upd_en(upd_en),
		.step(step), .action(action), .c_data_r(c_data_r), .need(need), .supply(supply),
		.today_month(today_month), .today_day(today_day), .barrel(barrel),
		.c_data_w(c_data_w), .overflow(overflow)
	);

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 4
) (
	output logic clk
);

	// free running, starts low
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

// File: sim/barrel_mem.sv
`timescale 1ns/1ns
`default_nettype none

module barrel_mem (
	input  logic              clk,
	input  logic              c_in_valid,
	input  logic              c_r_wb,
	input  bev_pkg::box_t     c_addr,
	input  bev_pkg::barrel_t  c_data_w,
	output logic              c_out_valid,
	output bev_pkg::barrel_t  c_data_r
);

	bev_pkg::barrel_t mem [0:255];
	bev_pkg::barrel_t last_write;
	int unsigned      write_count;
	logic [15:0]      lfsr;
	bev_pkg::box_t    req_addr;
	logic             req_read;
	int               delay;

	// 16-bit Fibonacci, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// reply delay of 1 to 4 cycles, one step per bit
	task automatic draw_delay(output int cycles);
		logic [1:0] bits;
		for (int i = 0; i < 2; i++) begin
			lfsr    = lfsr_next(lfsr);
			bits[i] = lfsr[0];
		end
		cycles = 1 + int'(bits);
	endtask

	initial begin
		c_out_valid = 1'b0;
		c_data_r    = '0;
		last_write  = '0;
		write_count = 0;
		lfsr        = 16'd77;
		// background pattern from the full address
		for (int a = 0; a < 256; a++) begin
			mem[a] = {8{8'(a)}} ^ 64'h0123_4567_89ab_cdef;
		end
		// ========================================
		// request capture mid cycle, reply after the edge
		// ========================================
		forever begin
			@(negedge clk);
			if (c_in_valid) begin
				req_addr = c_addr;
				req_read = c_r_wb;
				if (!c_r_wb) begin
					mem[c_addr] = c_data_w;
					last_write  = c_data_w;
					write_count++;
				end
				draw_delay(delay);
				repeat (delay) @(posedge clk);
				#1;
				// write reply is only an acknowledge
				if (req_read) c_data_r = mem[req_addr];
				c_out_valid = 1'b1;
				@(posedge clk);
				#1;
				c_out_valid = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: sim/bev_tb.sv
`timescale 1ns/1ns
`default_nettype none

module bev_tb;

	// one order with its expected outcome
	typedef struct packed {
		logic             act;
		logic [2:0]       bev;
		logic [1:0]       size;
		logic [3:0]       month;
		logic [4:0]       day;
		logic [7:0]       box;
		logic             late;
		logic [0:3][11:0] sup;
		logic [63:0]      rec;
		logic [1:0]       exp_err;
		logic             exp_complete;
		logic             exp_write;
		logic [63:0]      exp_rec;
	} order_t;

	logic             clk;
	logic             inf_n;
	bev_pkg::bus_t    d;
	logic             act_valid;
	logic             type_valid;
	logic             size_valid;
	logic             date_valid;
	logic             box_valid;
	logic             sup_valid;
	logic             c_out_valid;
	bev_pkg::barrel_t c_data_r;
	logic             out_valid;
	logic             complete;
	logic             c_in_valid;
	logic             c_r_wb;
	bev_pkg::err_t    err;
	bev_pkg::box_t    c_addr;
	bev_pkg::barrel_t c_data_w;

	order_t      orders [$];
	order_t      cur;
	int unsigned pulses;
	int unsigned writes_before;
	int unsigned writes_total;

	tb_clock clock_gen (.clk(clk));

	barrel_mem mem_model (
		.clk(clk), .c_in_valid(c_in_valid), .c_r_wb(c_r_wb), .c_addr(c_addr),
		.c_data_w(c_data_w), .c_out_valid(c_out_valid), .c_data_r(c_data_r)
	);

	bev_top uut (
		.clk(clk), .inf_n(inf_n), .d(d), .act_valid(act_valid), .type_valid(type_valid),
		.size_valid(size_valid), .date_valid(date_valid), .box_valid(box_valid),
		.sup_valid(sup_valid), .c_out_valid(c_out_valid), .c_data_r(c_data_r),
		.out_valid(out_valid), .complete(complete), .c_in_valid(c_in_valid),
		.c_r_wb(c_r_wb), .err(err), .c_addr(c_addr), .c_data_w(c_data_w)
	);

	// counts every result pulse including spurious ones
	always @(negedge clk) begin
		if (out_valid) pulses = pulses + 1;
	end

	// ========================================
	// reference model
	// ========================================
	// black, green, milk, pineapple fields packed into a record
	function automatic logic [63:0] barrel_rec(
		input logic [11:0] black,
		input logic [11:0] green,
		input logic [11:0] milk,
		input logic [11:0] pine,
		input logic [3:0]  month,
		input logic [4:0]  day
	);
		return {black, green, 4'd0, month, milk, pine, 3'd0, day};
	endfunction

	// quarters of the cup per ingredient with black in the top nibble
	function automatic logic [15:0] recipe_quarters(input logic [2:0] bev);
		case (bev)
			3'd0: return 16'h4000;
			3'd1: return 16'h3010;
			3'd2: return 16'h2020;
			3'd3: return 16'h0400;
			3'd4: return 16'h0220;
			3'd5: return 16'h0004;
			3'd6: return 16'h2002;
			default: return 16'h2011;
		endcase
	endfunction

	function automatic order_t predict(input order_t o);
		int          lsb [0:3];
		logic [11:0] vol;
		logic [11:0] have;
		logic [11:0] need;
		logic [12:0] sum;
		logic [15:0] q;
		logic        expired;
		logic        short;
		logic        ovf;
		lsb = '{52, 40, 20, 8};
		vol = (o.size == 2'd0) ? 12'd960 : ((o.size == 2'd1) ? 12'd720 : 12'd480);
		q = recipe_quarters(o.bev);
		o.exp_rec = o.rec;
		short = 1'b0;
		ovf = 1'b0;
		for (int i = 0; i < 4; i++) begin
			have = o.rec[lsb[i] +: 12];
			need = 12'((32'(vol) * 32'(q[15 - 4 * i -: 4])) / 4);
			if (o.act) begin
				// add and clip at a full barrel
				sum = {1'b0, have} + {1'b0, o.sup[i]};
				if (sum > 13'd4095) begin
					ovf = 1'b1;
					sum = 13'd4095;
				end
				o.exp_rec[lsb[i] +: 12] = sum[11:0];
			end else begin
				if (have < need) short = 1'b1;
				o.exp_rec[lsb[i] +: 12] = have - need;
			end
		end
		// only the low month and day bits count
		expired = (o.rec[35:32] < o.month) || ((o.rec[35:32] == o.month) && (o.rec[4:0] < o.day));
		if (o.act) begin
			o.exp_rec[39:32] = {4'd0, o.month};
			o.exp_rec[7:0]   = {3'd0, o.day};
			o.exp_err        = ovf ? bev_pkg::Ing_OF : bev_pkg::No_Err;
			o.exp_complete   = !ovf;
			o.exp_write      = 1'b1;
		end else begin
			o.exp_err        = expired ? bev_pkg::No_Exp : (short ? bev_pkg::No_Ing : bev_pkg::No_Err);
			o.exp_complete   = !expired && !short;
			o.exp_write      = !expired && !short;
		end
		return o;
	endfunction

	function automatic order_t new_order(
		input logic             act,
		input logic [2:0]       bev,
		input logic [1:0]       size,
		input logic [3:0]       month,
		input logic [4:0]       day,
		input logic [7:0]       box,
		input logic             late,
		input logic [0:3][11:0] sup,
		input logic [63:0]      rec
	);
		order_t o;
		o       = '0;
		o.act   = act;
		o.bev   = bev;
		o.size  = size;
		o.month = month;
		o.day   = day;
		o.box   = box;
		o.late  = late;
		o.sup   = sup;
		o.rec   = rec;
		return predict(o);
	endfunction

	// ========================================
	// order table
	// ========================================
	task automatic build_orders();
		// milk tea L with plenty left and a later date
		orders.push_back(new_order(bev_pkg::Make_drink, bev_pkg::Milk_Tea, bev_pkg::L, 4'd5, 5'd20,
			8'd3, 1'b0, '0, barrel_rec(12'd2000, 12'd500, 12'd800, 12'd300, 4'd6, 5'd15)));
		// same month with the barrel day one behind
		orders.push_back(new_order(bev_pkg::Make_drink, bev_pkg::Black_Tea, bev_pkg::M, 4'd4, 5'd11,
			8'd5, 1'b0, '0, barrel_rec(12'd3000, 12'd3000, 12'd3000, 12'd3000, 4'd4, 5'd10)));
		// milk 100 under the 120 needed
		orders.push_back(new_order(bev_pkg::Make_drink, bev_pkg::Super_Pineapple_Milk_Tea,
			bev_pkg::S, 4'd1, 5'd1, 8'd7, 1'b0, '0,
			barrel_rec(12'd1000, 12'd0, 12'd100, 12'd500, 4'd12, 5'd31)));
		// expired and short so expiry is reported
		orders.push_back(new_order(bev_pkg::Make_drink, bev_pkg::Super_Pineapple_Milk_Tea,
			bev_pkg::S, 4'd3, 5'd1, 8'd9, 1'b0, '0,
			barrel_rec(12'd1000, 12'd0, 12'd50, 12'd500, 4'd2, 5'd3)));
		// plain supply
		orders.push_back(new_order(bev_pkg::Supply, 3'd0, 2'd0, 4'd8, 5'd9, 8'd11, 1'b0,
			{12'd100, 12'd200, 12'd300, 12'd400},
			barrel_rec(12'd1000, 12'd1000, 12'd1000, 12'd1000, 4'd1, 5'd1)));
		// green tea overflows with amounts after the read
		orders.push_back(new_order(bev_pkg::Supply, 3'd0, 2'd0, 4'd9, 5'd30, 8'd13, 1'b1,
			{12'd10, 12'd200, 12'd20, 12'd30},
			barrel_rec(12'd500, 12'd4000, 12'd600, 12'd700, 4'd3, 5'd2)));
		// date equal to today is still good
		orders.push_back(new_order(bev_pkg::Make_drink, bev_pkg::Green_Tea, bev_pkg::M, 4'd7, 5'd7,
			8'd15, 1'b0, '0, barrel_rec(12'd0, 12'd800, 12'd0, 12'd0, 4'd7, 5'd7)));
		// fills to exactly 4095 without overflow
		orders.push_back(new_order(bev_pkg::Supply, 3'd0, 2'd0, 4'd2, 5'd14, 8'd17, 1'b1,
			{12'd4095, 12'd0, 12'd0, 12'd1},
			barrel_rec(12'd0, 12'd10, 12'd20, 12'd4094, 4'd1, 5'd1)));
		// exactly enough pineapple
		orders.push_back(new_order(bev_pkg::Make_drink, bev_pkg::Pineapple_Juice, bev_pkg::L,
			4'd10, 5'd5, 8'd20, 1'b0, '0,
			barrel_rec(12'd0, 12'd0, 12'd0, 12'd960, 4'd11, 5'd1)));
		// milk one short of half
		orders.push_back(new_order(bev_pkg::Make_drink, bev_pkg::Extra_Milk_Tea, bev_pkg::S,
			4'd6, 5'd1, 8'd22, 1'b0, '0,
			barrel_rec(12'd240, 12'd0, 12'd239, 12'd0, 4'd6, 5'd2)));
		orders.push_back(new_order(bev_pkg::Make_drink, bev_pkg::Super_Pineapple_Tea, bev_pkg::M,
			4'd1, 5'd31, 8'd24, 1'b0, '0,
			barrel_rec(12'd360, 12'd0, 12'd0, 12'd360, 4'd1, 5'd31)));
	endtask

	// ========================================
	// drive and compare
	// ========================================
	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("Error: %0t ns %s got %h expected %h", $time, name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// one hot strobes in the order act type size date box sup
	task automatic send_word(input logic [5:0] strobes, input logic [11:0] word);
		@(posedge clk);
		#1;
		d = word;
		{act_valid, type_valid, size_valid, date_valid, box_valid, sup_valid} = strobes;
		@(posedge clk);
		#1;
		{act_valid, type_valid, size_valid, date_valid, box_valid, sup_valid} = 6'b0;
	endtask

	task automatic wait_read_reply();
		int n;
		n = 0;
		while (!c_out_valid && n < 50) begin
			@(negedge clk);
			n++;
		end
		if (!c_out_valid) begin
			$display("Timed out waiting for the memory read reply");
			$display("STATUS: FAIL");
			$fatal(1, "read reply timeout");
		end
	endtask

	task automatic wait_result();
		int n;
		n = 0;
		@(negedge clk);
		while (!out_valid && n < 200) begin
			@(negedge clk);
			n++;
		end
		if (!out_valid) begin
			$display("Timed out waiting for out_valid");
			$display("STATUS: FAIL");
			$fatal(1, "result timeout");
		end
	endtask

	initial begin
		inf_n = 1'b0;
		d = '0;
		{act_valid, type_valid, size_valid, date_valid, box_valid, sup_valid} = 6'b0;
		pulses = 0;
		writes_total = 0;
		repeat (4) @(posedge clk);
		#1;
		inf_n = 1'b1;
		// idle outputs straight after reset
		@(negedge clk);
		compare("out_valid", out_valid, 1'b0);
		compare("c_in_valid", c_in_valid, 1'b0);
		compare("err", err, bev_pkg::No_Err);
		compare("complete", complete, 1'b0);
		build_orders();
		foreach (orders[i]) mem_model.mem[orders[i].box] = orders[i].rec;
		for (int i = 0; i < orders.size(); i++) begin
			cur = orders[i];
			writes_before = mem_model.write_count;
			send_word(6'b100000, {11'd0, cur.act});
			if (!cur.act) begin
				send_word(6'b010000, {9'd0, cur.bev});
				send_word(6'b001000, {10'd0, cur.size});
			end
			send_word(6'b000100, {3'd0, cur.month, cur.day});
			send_word(6'b000010, {4'd0, cur.box});
			if (cur.act) begin
				if (cur.late) wait_read_reply();
				for (int k = 0; k < 4; k++) send_word(6'b000001, cur.sup[k]);
			end
			wait_result();
			compare("err", err, cur.exp_err);
			compare("complete", complete, cur.exp_complete);
			compare("write count", mem_model.write_count, writes_before + cur.exp_write);
			if (cur.exp_write) begin
				compare("c_data_w", mem_model.last_write, cur.exp_rec);
				// record must land back in the ordered box
				compare("record at c_addr", mem_model.mem[cur.box], cur.exp_rec);
			end
			writes_total += cur.exp_write;
			// counter settles on the next edge
			@(posedge clk);
			#1;
			compare("out_valid pulses", pulses, i + 1);
		end
		repeat (10) @(posedge clk);
		compare("out_valid pulses", pulses, orders.size());
		compare("total writes", mem_model.write_count, writes_total);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
logic/bev_pkg.sv
logic/bev_ctrl.sv
logic/order_capture.sv
logic/recipe_check.sv
logic/barrel_update.sv
logic/bev_top.sv
sim/tb_clock.sv
sim/barrel_mem.sv
sim/bev_tb.sv

// File: Bender.yml
package:
  name: bev_barrel

sources:
  - logic/bev_pkg.sv
  - logic/bev_ctrl.sv
  - logic/order_capture.sv
  - logic/recipe_check.sv
  - logic/barrel_update.sv
  - logic/bev_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/barrel_mem.sv
      - sim/bev_tb.sv
